/* rr_isa_pkg.sv */
`default_nettype none

package rr_isa_pkg;

    // architectural widths
    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;
    localparam int NUM_REGS  = 32;

    // data word, used for operands, pc, inst and imm
    typedef logic [XLEN-1:0] word_t;
    // r0 reads as zero and never carries a hazard
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // micro-op layout
    localparam int UOP_W        = 12;
    localparam int UOP_MEM_BIT  = 0;
    localparam int UOP_COND_LSB = 4;
    localparam int UOP_COND_W   = 4;
    // bit inside the cond field, set for stores
    localparam int COND_STORE_BIT = 2;

    typedef logic [UOP_W-1:0] uop_t;

    // andi r0, r0, 0
    localparam word_t INST_NOP = 32'h03400000;

endpackage

`default_nettype wire

/* rr_pipe_pkg.sv */
`default_nettype none

package rr_pipe_pkg;

    // two issue lanes, lane 1 is the younger
    localparam int NUM_LANES = 2;

    // read ports in order rj0, rj1, rk0, rk1
    localparam int NUM_SRC = 4;

    // older load destinations kept after the load leaves execute
    localparam int LOAD_HIST_DEPTH = 2;

    // entry 0 is the most recent
    typedef logic [LOAD_HIST_DEPTH-1:0][rr_isa_pkg::REG_IDX_W-1:0] load_hist_t;

endpackage

`default_nettype wire

/* dual_regfile.sv */
`default_nettype none

module dual_regfile (
    input  wire logic                 clk,
    input  wire logic                 aresetn,
    input  wire logic                 we0,
    input  wire rr_isa_pkg::reg_idx_t waddr0,
    input  wire rr_isa_pkg::word_t    wdata0,
    input  wire logic                 we1,
    input  wire rr_isa_pkg::reg_idx_t waddr1,
    input  wire rr_isa_pkg::word_t    wdata1,
    input  wire rr_isa_pkg::reg_idx_t raddr_j0,
    input  wire rr_isa_pkg::reg_idx_t raddr_j1,
    input  wire rr_isa_pkg::reg_idx_t raddr_k0,
    input  wire rr_isa_pkg::reg_idx_t raddr_k1,
    output rr_isa_pkg::word_t         rdata_j0,
    output rr_isa_pkg::word_t         rdata_j1,
    output rr_isa_pkg::word_t         rdata_k0,
    output rr_isa_pkg::word_t         rdata_k1
);

    // write ports by lane
    logic                 we    [rr_pipe_pkg::NUM_LANES];
    rr_isa_pkg::reg_idx_t waddr [rr_pipe_pkg::NUM_LANES];
    rr_isa_pkg::word_t    wdata [rr_pipe_pkg::NUM_LANES];

    // no storage behind r0
    rr_isa_pkg::word_t regs [1:rr_isa_pkg::NUM_REGS-1];

    assign we[0]    = we0;
    assign waddr[0] = waddr0;
    assign wdata[0] = wdata0;
    assign we[1]    = we1;
    assign waddr[1] = waddr1;
    assign wdata[1] = wdata1;

    // one read port with write-first bypass
    function automatic rr_isa_pkg::word_t read_port(input rr_isa_pkg::reg_idx_t addr);
        rr_isa_pkg::word_t data;
        if (addr == '0) begin
            data = '0;
        end else begin
            data = regs[addr];
            // lane 0 first, so lane 1 overrides on a shared index
            for (int i = 0; i < rr_pipe_pkg::NUM_LANES; i++) begin
                if (we[i] && waddr[i] == addr) begin
                    data = wdata[i];
                end
            end
        end
        return data;
    endfunction

    // combinational reads, same cycle as decode indices
    always_comb begin
        rdata_j0 = read_port(raddr_j0);
        rdata_j1 = read_port(raddr_j1);
        rdata_k0 = read_port(raddr_k0);
        rdata_k1 = read_port(raddr_k1);
    end

    // later nba wins, lane 1 takes a doubly written register
    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            for (int r = 1; r < rr_isa_pkg::NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int i = 0; i < rr_pipe_pkg::NUM_LANES; i++) begin
                // writes to r0 dropped
                if (we[i] && waddr[i] != '0) begin
                    regs[waddr[i]] <= wdata[i];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* load_use_scoreboard.sv */
`default_nettype none

module load_use_scoreboard (
    input  wire logic                 clk,
    input  wire logic                 aresetn,
    input  wire logic                 ex_fire,
    input  wire rr_isa_pkg::uop_t     ex_uop0,
    input  wire rr_isa_pkg::reg_idx_t ex_rd0,
    input  wire rr_isa_pkg::reg_idx_t id_rj0,
    input  wire rr_isa_pkg::reg_idx_t id_rj1,
    input  wire rr_isa_pkg::reg_idx_t id_rk0,
    input  wire rr_isa_pkg::reg_idx_t id_rk1,
    output logic                      load_stall
);

    // cond field of the lane 0 uop in execute
    logic [rr_isa_pkg::UOP_COND_W-1:0] cond;
    logic                              is_load;
    // load destination, zero for non-loads
    rr_isa_pkg::reg_idx_t              ld_rd;
    rr_pipe_pkg::load_hist_t           hist;
    // decode sources, rj0 rj1 rk0 rk1
    rr_isa_pkg::reg_idx_t              src [rr_pipe_pkg::NUM_SRC];

    assign cond    = ex_uop0[rr_isa_pkg::UOP_COND_LSB +: rr_isa_pkg::UOP_COND_W];
    // memory op that is not a store
    assign is_load = ex_uop0[rr_isa_pkg::UOP_MEM_BIT] & ~cond[rr_isa_pkg::COND_STORE_BIT];
    assign ld_rd   = is_load ? ex_rd0 : '0;

    assign src[0] = id_rj0;
    assign src[1] = id_rj1;
    assign src[2] = id_rk0;
    assign src[3] = id_rk1;

    // history steps once per execute advance
    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            hist <= '0;
        end else if (ex_fire) begin
            for (int d = rr_pipe_pkg::LOAD_HIST_DEPTH - 1; d > 0; d--) begin
                hist[d] <= hist[d-1];
            end
            hist[0] <= ld_rd;
        end
    end

    // match any source against the current load or the history
    always_comb begin
        load_stall = 1'b0;
        for (int s = 0; s < rr_pipe_pkg::NUM_SRC; s++) begin
            if (ld_rd != '0 && src[s] == ld_rd) begin
                load_stall = 1'b1;
            end
            for (int d = 0; d < rr_pipe_pkg::LOAD_HIST_DEPTH; d++) begin
                // zero entries are empty slots
                if (hist[d] != '0 && src[s] == hist[d]) begin
                    load_stall = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* ex_issue_reg.sv */
`default_nettype none

module ex_issue_reg (
    input  wire logic                 clk,
    input  wire logic                 aresetn,
    input  wire logic                 flush,
    input  wire logic                 reg_readygo,
    input  wire logic                 ex_allowin,
    input  wire logic                 forward_stall,
    input  wire logic                 load_stall,
    input  wire rr_isa_pkg::word_t    id_pc0,
    input  wire rr_isa_pkg::word_t    id_pc1,
    input  wire rr_isa_pkg::word_t    id_inst0,
    input  wire rr_isa_pkg::word_t    id_inst1,
    input  wire rr_isa_pkg::word_t    id_imm0,
    input  wire rr_isa_pkg::word_t    id_imm1,
    input  wire rr_isa_pkg::uop_t     id_uop0,
    input  wire rr_isa_pkg::uop_t     id_uop1,
    input  wire rr_isa_pkg::reg_idx_t id_rj0,
    input  wire rr_isa_pkg::reg_idx_t id_rj1,
    input  wire rr_isa_pkg::reg_idx_t id_rk0,
    input  wire rr_isa_pkg::reg_idx_t id_rk1,
    input  wire rr_isa_pkg::reg_idx_t id_rd0,
    input  wire rr_isa_pkg::reg_idx_t id_rd1,
    input  wire rr_isa_pkg::word_t    rj0_data,
    input  wire rr_isa_pkg::word_t    rj1_data,
    input  wire rr_isa_pkg::word_t    rk0_data,
    input  wire rr_isa_pkg::word_t    rk1_data,
    input  wire logic                 fwd_flag_j0,
    input  wire logic                 fwd_flag_j1,
    input  wire logic                 fwd_flag_k0,
    input  wire logic                 fwd_flag_k1,
    input  wire rr_isa_pkg::word_t    fwd_data_j0,
    input  wire rr_isa_pkg::word_t    fwd_data_j1,
    input  wire rr_isa_pkg::word_t    fwd_data_k0,
    input  wire rr_isa_pkg::word_t    fwd_data_k1,
    output logic                      reg_allowin,
    output logic                      ex_readygo,
    output logic                      ex_fire,
    output rr_isa_pkg::word_t         ex_pc0,
    output rr_isa_pkg::word_t         ex_pc1,
    output rr_isa_pkg::word_t         ex_inst0,
    output rr_isa_pkg::word_t         ex_inst1,
    output rr_isa_pkg::word_t         ex_imm0,
    output rr_isa_pkg::word_t         ex_imm1,
    output rr_isa_pkg::uop_t          ex_uop0,
    output rr_isa_pkg::uop_t          ex_uop1,
    output rr_isa_pkg::reg_idx_t      ex_rj0,
    output rr_isa_pkg::reg_idx_t      ex_rj1,
    output rr_isa_pkg::reg_idx_t      ex_rk0,
    output rr_isa_pkg::reg_idx_t      ex_rk1,
    output rr_isa_pkg::reg_idx_t      ex_rd0,
    output rr_isa_pkg::reg_idx_t      ex_rd1,
    output rr_isa_pkg::word_t         ex_rj0_data,
    output rr_isa_pkg::word_t         ex_rj1_data,
    output rr_isa_pkg::word_t         ex_rk0_data,
    output rr_isa_pkg::word_t         ex_rk1_data
);

    logic capture;
    logic bubble;

    // operands by source, order rj0 rj1 rk0 rk1
    rr_isa_pkg::word_t rf_data  [rr_pipe_pkg::NUM_SRC];
    logic              fwd_flag [rr_pipe_pkg::NUM_SRC];
    rr_isa_pkg::word_t fwd_data [rr_pipe_pkg::NUM_SRC];
    rr_isa_pkg::word_t opnd_q   [rr_pipe_pkg::NUM_SRC];

    // stage handshake
    assign ex_readygo  = ~forward_stall;
    assign reg_allowin = ex_allowin & ~forward_stall & ~load_stall;
    assign ex_fire     = ex_allowin & ex_readygo;
    assign capture     = reg_readygo & reg_allowin;
    // flush, or entry leaves with nothing behind it
    assign bubble      = flush | (ex_fire & ~capture);

    assign rf_data  = '{rj0_data, rj1_data, rk0_data, rk1_data};
    assign fwd_flag = '{fwd_flag_j0, fwd_flag_j1, fwd_flag_k0, fwd_flag_k1};
    assign fwd_data = '{fwd_data_j0, fwd_data_j1, fwd_data_k0, fwd_data_k1};

    assign ex_rj0_data = opnd_q[0];
    assign ex_rj1_data = opnd_q[1];
    assign ex_rk0_data = opnd_q[2];
    assign ex_rk1_data = opnd_q[3];

    // instruction fields, hold when neither bubble nor capture
    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            ex_pc0   <= '0;
            ex_pc1   <= '0;
            ex_inst0 <= rr_isa_pkg::INST_NOP;
            ex_inst1 <= rr_isa_pkg::INST_NOP;
            ex_imm0  <= '0;
            ex_imm1  <= '0;
            ex_uop0  <= '0;
            ex_uop1  <= '0;
            ex_rj0   <= '0;
            ex_rj1   <= '0;
            ex_rk0   <= '0;
            ex_rk1   <= '0;
            ex_rd0   <= '0;
            ex_rd1   <= '0;
        end else if (bubble) begin
            // nop pair, zero rd so no hazard or writeback
            ex_pc0   <= '0;
            ex_pc1   <= '0;
            ex_inst0 <= rr_isa_pkg::INST_NOP;
            ex_inst1 <= rr_isa_pkg::INST_NOP;
            ex_imm0  <= '0;
            ex_imm1  <= '0;
            ex_uop0  <= '0;
            ex_uop1  <= '0;
            ex_rj0   <= '0;
            ex_rj1   <= '0;
            ex_rk0   <= '0;
            ex_rk1   <= '0;
            ex_rd0   <= '0;
            ex_rd1   <= '0;
        end else if (capture) begin
            ex_pc0   <= id_pc0;
            ex_pc1   <= id_pc1;
            ex_inst0 <= id_inst0;
            ex_inst1 <= id_inst1;
            ex_imm0  <= id_imm0;
            ex_imm1  <= id_imm1;
            ex_uop0  <= id_uop0;
            ex_uop1  <= id_uop1;
            ex_rj0   <= id_rj0;
            ex_rj1   <= id_rj1;
            ex_rk0   <= id_rk0;
            ex_rk1   <= id_rk1;
            ex_rd0   <= id_rd0;
            ex_rd1   <= id_rd1;
        end
    end

    // operands, patched from forwarding while held
    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            for (int s = 0; s < rr_pipe_pkg::NUM_SRC; s++) begin
                opnd_q[s] <= '0;
            end
        end else begin
            for (int s = 0; s < rr_pipe_pkg::NUM_SRC; s++) begin
                if (bubble) begin
                    opnd_q[s] <= '0;
                end else if (capture) begin
                    opnd_q[s] <= rf_data[s];
                end else if (fwd_flag[s]) begin
                    // producer result arrived late
                    opnd_q[s] <= fwd_data[s];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* reg_read_stage.sv */
`default_nettype none

module reg_read_stage (
    input  wire logic                 clk,
    input  wire logic                 aresetn,
    input  wire logic                 flush,
    input  wire logic                 reg_readygo,
    input  wire logic                 ex_allowin,
    input  wire logic                 forward_stall,
    input  wire rr_isa_pkg::word_t    id_pc0,
    input  wire rr_isa_pkg::word_t    id_pc1,
    input  wire rr_isa_pkg::word_t    id_inst0,
    input  wire rr_isa_pkg::word_t    id_inst1,
    input  wire rr_isa_pkg::word_t    id_imm0,
    input  wire rr_isa_pkg::word_t    id_imm1,
    input  wire rr_isa_pkg::uop_t     id_uop0,
    input  wire rr_isa_pkg::uop_t     id_uop1,
    input  wire rr_isa_pkg::reg_idx_t id_rj0,
    input  wire rr_isa_pkg::reg_idx_t id_rj1,
    input  wire rr_isa_pkg::reg_idx_t id_rk0,
    input  wire rr_isa_pkg::reg_idx_t id_rk1,
    input  wire rr_isa_pkg::reg_idx_t id_rd0,
    input  wire rr_isa_pkg::reg_idx_t id_rd1,
    input  wire logic                 wb_we0,
    input  wire logic                 wb_we1,
    input  wire rr_isa_pkg::reg_idx_t wb_rd0,
    input  wire rr_isa_pkg::reg_idx_t wb_rd1,
    input  wire rr_isa_pkg::word_t    wb_data0,
    input  wire rr_isa_pkg::word_t    wb_data1,
    input  wire logic                 fwd_flag_j0,
    input  wire logic                 fwd_flag_j1,
    input  wire logic                 fwd_flag_k0,
    input  wire logic                 fwd_flag_k1,
    input  wire rr_isa_pkg::word_t    fwd_data_j0,
    input  wire rr_isa_pkg::word_t    fwd_data_j1,
    input  wire rr_isa_pkg::word_t    fwd_data_k0,
    input  wire rr_isa_pkg::word_t    fwd_data_k1,
    output wire logic                 reg_allowin,
    output wire logic                 ex_readygo,
    output wire rr_isa_pkg::word_t    ex_pc0,
    output wire rr_isa_pkg::word_t    ex_pc1,
    output wire rr_isa_pkg::word_t    ex_inst0,
    output wire rr_isa_pkg::word_t    ex_inst1,
    output wire rr_isa_pkg::word_t    ex_imm0,
    output wire rr_isa_pkg::word_t    ex_imm1,
    output wire rr_isa_pkg::uop_t     ex_uop0,
    output wire rr_isa_pkg::uop_t     ex_uop1,
    output wire rr_isa_pkg::reg_idx_t ex_rj0,
    output wire rr_isa_pkg::reg_idx_t ex_rj1,
    output wire rr_isa_pkg::reg_idx_t ex_rk0,
    output wire rr_isa_pkg::reg_idx_t ex_rk1,
    output wire rr_isa_pkg::reg_idx_t ex_rd0,
    output wire rr_isa_pkg::reg_idx_t ex_rd1,
    output wire rr_isa_pkg::word_t    ex_rj0_data,
    output wire rr_isa_pkg::word_t    ex_rj1_data,
    output wire rr_isa_pkg::word_t    ex_rk0_data,
    output wire rr_isa_pkg::word_t    ex_rk1_data
);

    // regfile read data into the issue register
    wire rr_isa_pkg::word_t rj0_data;
    wire rr_isa_pkg::word_t rj1_data;
    wire rr_isa_pkg::word_t rk0_data;
    wire rr_isa_pkg::word_t rk1_data;
    wire logic              load_stall;
    // execute advance that steps the load history
    wire logic              ex_fire;

    // writeback lanes map straight onto the two write ports
    dual_regfile u_regfile (
        .clk      (clk),
        .aresetn  (aresetn),
        .we0      (wb_we0),
        .waddr0   (wb_rd0),
        .wdata0   (wb_data0),
        .we1      (wb_we1),
        .waddr1   (wb_rd1),
        .wdata1   (wb_data1),
        .raddr_j0 (id_rj0),
        .raddr_j1 (id_rj1),
        .raddr_k0 (id_rk0),
        .raddr_k1 (id_rk1),
        .rdata_j0 (rj0_data),
        .rdata_j1 (rj1_data),
        .rdata_k0 (rk0_data),
        .rdata_k1 (rk1_data)
    );

    // checks decode sources against loads in and behind execute
    load_use_scoreboard u_scoreboard (
        .clk        (clk),
        .aresetn    (aresetn),
        .ex_fire    (ex_fire),
        .ex_uop0    (ex_uop0),
        .ex_rd0     (ex_rd0),
        .id_rj0     (id_rj0),
        .id_rj1     (id_rj1),
        .id_rk0     (id_rk0),
        .id_rk1     (id_rk1),
        .load_stall (load_stall)
    );

    // stage handshake and the pipeline register toward execute
    ex_issue_reg u_issue (.*);

endmodule

`default_nettype wire

/* tb_reg_read_stage.sv */
`default_nettype none

module tb_reg_read_stage;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_ROWS   = 26;
    // one cycle per row, margin for reset and drain
    localparam int MAX_CYCLES = NUM_ROWS * 2 + 20;

    // lane 0 micro-op kinds
    localparam logic [1:0] ALU = 2'd0;
    localparam logic [1:0] LD  = 2'd1;
    localparam logic [1:0] ST  = 2'd2;
    // outcome of a row at its clock edge
    localparam logic [1:0] CAP = 2'd0;
    localparam logic [1:0] HLD = 2'd1;
    localparam logic [1:0] BUB = 2'd2;

    typedef struct packed {
        logic                 rgo;
        logic                 alw;
        logic                 fst;
        logic                 fl;
        logic                 we0;
        rr_isa_pkg::reg_idx_t wrd0;
        logic                 we1;
        rr_isa_pkg::reg_idx_t wrd1;
        rr_isa_pkg::reg_idx_t rj0;
        rr_isa_pkg::reg_idx_t rj1;
        rr_isa_pkg::reg_idx_t rk0;
        rr_isa_pkg::reg_idx_t rk1;
        rr_isa_pkg::reg_idx_t rd0;
        logic [1:0]           kind;
        // bit 0 j0, bit 1 j1, bit 2 k0, bit 3 k1
        logic [3:0]           fwd;
        logic                 e_alw;
        logic                 e_rgo;
        logic [1:0]           e_act;
    } row_t;

    logic                 clk = 1'b0;
    logic                 aresetn;
    logic                 flush, reg_readygo, ex_allowin, forward_stall;
    rr_isa_pkg::word_t    id_pc0, id_pc1, id_inst0, id_inst1, id_imm0, id_imm1;
    rr_isa_pkg::uop_t     id_uop0, id_uop1;
    rr_isa_pkg::reg_idx_t id_rj0, id_rj1, id_rk0, id_rk1, id_rd0, id_rd1;
    logic                 wb_we0, wb_we1;
    rr_isa_pkg::reg_idx_t wb_rd0, wb_rd1;
    rr_isa_pkg::word_t    wb_data0, wb_data1;
    logic                 fwd_flag_j0, fwd_flag_j1, fwd_flag_k0, fwd_flag_k1;
    rr_isa_pkg::word_t    fwd_data_j0, fwd_data_j1, fwd_data_k0, fwd_data_k1;
    wire logic                 reg_allowin, ex_readygo;
    wire rr_isa_pkg::word_t    ex_pc0, ex_pc1, ex_inst0, ex_inst1, ex_imm0, ex_imm1;
    wire rr_isa_pkg::uop_t     ex_uop0, ex_uop1;
    wire rr_isa_pkg::reg_idx_t ex_rj0, ex_rj1, ex_rk0, ex_rk1, ex_rd0, ex_rd1;
    wire rr_isa_pkg::word_t    ex_rj0_data, ex_rj1_data, ex_rk0_data, ex_rk1_data;

    row_t                 tbl [NUM_ROWS];
    // architectural registers as seen by the testbench
    rr_isa_pkg::word_t    shadow [32];
    // expected ex outputs, same order as field_name
    rr_isa_pkg::word_t    m_entry [18];
    logic                 m_load;
    rr_isa_pkg::reg_idx_t m_hist [rr_pipe_pkg::LOAD_HIST_DEPTH];
    logic [31:0]          lfsr = 32'h37232b87;
    int                   errors = 0;
    int                   cycles = 0;
    string field_name [18] = '{"ex_pc0", "ex_pc1", "ex_inst0", "ex_inst1", "ex_imm0",
        "ex_imm1", "ex_uop0", "ex_uop1", "ex_rj0", "ex_rj1", "ex_rk0", "ex_rk1", "ex_rd0",
        "ex_rd1", "ex_rj0_data", "ex_rj1_data", "ex_rk0_data", "ex_rk1_data"};

    reg_read_stage u_dut (.*);

    always #20 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Run timed out after %0d cycles before the table was done", cycles);
            $display("Finished with errors");
            $finish;
        end
    end

    // galois step, taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    task automatic rand_word(output rr_isa_pkg::word_t w);
        for (int b = 0; b < 32; b++) begin
            lfsr = lfsr_step(lfsr);
            w[b] = lfsr[0];
        end
    endtask

    // mem bit 0, cond field from bit 4, cond bit 2 set for stores
    function automatic rr_isa_pkg::uop_t uop_of(input logic [1:0] kind);
        case (kind)
            LD:      return 12'h011;
            ST:      return 12'h041;
            default: return 12'h100;
        endcase
    endfunction

    // same-cycle writes visible, lane 1 checked first so it wins
    function automatic rr_isa_pkg::word_t shadow_read(input rr_isa_pkg::reg_idx_t idx,
            input row_t r, input rr_isa_pkg::word_t wd0, input rr_isa_pkg::word_t wd1);
        if (idx == 0)
            return '0;
        if (r.we1 && r.wrd1 == idx)
            return wd1;
        if (r.we0 && r.wrd0 == idx)
            return wd0;
        return shadow[idx];
    endfunction

    task automatic check_val(input string name, input rr_isa_pkg::word_t got,
            input rr_isa_pkg::word_t exp);
        assert (got === exp) else begin
            errors++;
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, got);
        end
    endtask

    // nop pair with zero fields
    task automatic model_bubble();
        foreach (m_entry[f])
            m_entry[f] = '0;
        m_entry[2] = rr_isa_pkg::INST_NOP;
        m_entry[3] = rr_isa_pkg::INST_NOP;
        m_load = 1'b0;
    endtask

    task automatic check_entry();
        rr_isa_pkg::word_t got [18];
        got = '{ex_pc0, ex_pc1, ex_inst0, ex_inst1, ex_imm0, ex_imm1,
                32'(ex_uop0), 32'(ex_uop1), 32'(ex_rj0), 32'(ex_rj1), 32'(ex_rk0),
                32'(ex_rk1), 32'(ex_rd0), 32'(ex_rd1),
                ex_rj0_data, ex_rj1_data, ex_rk0_data, ex_rk1_data};
        for (int f = 0; f < 18; f++) begin
            check_val(field_name[f], got[f], m_entry[f]);
        end
    endtask

    task automatic run_row(input int n);
        row_t                 r;
        rr_isa_pkg::word_t    wd0, wd1, pc0, pc1, in0, in1, im0, im1;
        rr_isa_pkg::word_t    fd [4];
        rr_isa_pkg::reg_idx_t src [4];
        rr_isa_pkg::reg_idx_t ld_rd;
        rr_isa_pkg::reg_idx_t rd1;
        logic                 stall, fire, cap, exp_alw, exp_rgo;
        logic [1:0]           act;
        r = tbl[n];
        rd1 = r.rd0 ^ 5'h1f;
        rand_word(wd0);
        rand_word(wd1);
        rand_word(pc0);
        rand_word(pc1);
        rand_word(in0);
        rand_word(in1);
        rand_word(im0);
        rand_word(im1);
        foreach (fd[s])
            rand_word(fd[s]);
        @(posedge clk);
        {reg_readygo, ex_allowin, forward_stall, flush} <= {r.rgo, r.alw, r.fst, r.fl};
        {wb_we0, wb_rd0, wb_data0} <= {r.we0, r.wrd0, wd0};
        {wb_we1, wb_rd1, wb_data1} <= {r.we1, r.wrd1, wd1};
        {id_pc0, id_pc1, id_inst0, id_inst1} <= {pc0, pc1, in0, in1};
        {id_imm0, id_imm1} <= {im0, im1};
        {id_uop0, id_uop1} <= {uop_of(r.kind), uop_of(ALU)};
        {id_rj0, id_rj1, id_rk0, id_rk1} <= {r.rj0, r.rj1, r.rk0, r.rk1};
        {id_rd0, id_rd1} <= {r.rd0, rd1};
        {fwd_flag_k1, fwd_flag_k0, fwd_flag_j1, fwd_flag_j0} <= r.fwd;
        {fwd_data_j0, fwd_data_j1, fwd_data_k0, fwd_data_k1} <= {fd[0], fd[1], fd[2], fd[3]};
        @(negedge clk);
        // registers show the previous row's outcome here
        check_entry();
        src = '{r.rj0, r.rj1, r.rk0, r.rk1};
        ld_rd = m_load ? m_entry[12][4:0] : '0;
        stall = 1'b0;
        foreach (src[s]) begin
            if (src[s] != 0 && src[s] == ld_rd)
                stall = 1'b1;
            foreach (m_hist[d]) begin
                if (src[s] != 0 && src[s] == m_hist[d])
                    stall = 1'b1;
            end
        end
        fire    = r.alw & ~r.fst;
        cap     = r.rgo & fire & ~stall;
        exp_alw = fire & ~stall;
        exp_rgo = ~r.fst;
        if (r.fl || (fire && !cap))
            act = BUB;
        else if (cap)
            act = CAP;
        else
            act = HLD;
        check_val("reg_allowin", 32'(reg_allowin), 32'(exp_alw));
        check_val("ex_readygo", 32'(ex_readygo), 32'(exp_rgo));
        assert (act == r.e_act && exp_alw == r.e_alw && exp_rgo == r.e_rgo) else begin
            errors++;
            $display("Row %0d of the stimulus table disagrees with the reference model", n);
        end
        // load history advances with execute
        if (fire) begin
            for (int d = rr_pipe_pkg::LOAD_HIST_DEPTH - 1; d > 0; d--)
                m_hist[d] = m_hist[d-1];
            m_hist[0] = ld_rd;
        end
        if (act == BUB) begin
            model_bubble();
        end else if (act == CAP) begin
            m_entry = '{pc0, pc1, in0, in1, im0, im1, 32'(uop_of(r.kind)), 32'(uop_of(ALU)),
                        32'(r.rj0), 32'(r.rj1), 32'(r.rk0), 32'(r.rk1), 32'(r.rd0), 32'(rd1),
                        shadow_read(r.rj0, r, wd0, wd1), shadow_read(r.rj1, r, wd0, wd1),
                        shadow_read(r.rk0, r, wd0, wd1), shadow_read(r.rk1, r, wd0, wd1)};
            m_load = (r.kind == LD);
        end else begin
            // held entry picks up late results
            foreach (fd[s]) begin
                if (r.fwd[s])
                    m_entry[14 + s] = fd[s];
            end
        end
        if (r.we0 && r.wrd0 != 0)
            shadow[r.wrd0] = wd0;
        if (r.we1 && r.wrd1 != 0)
            shadow[r.wrd1] = wd1;
    endtask

    initial begin
        //         rgo alw fst fl we0 wa0 we1 wa1 rj0 rj1 rk0 rk1 rd0 kind fwd  ea er act
        // r0 reads, bypass on r5 r6, both ports on r9, write to r0 dropped
        tbl[0]  = '{1, 1, 0, 0, 1, 1, 1, 2, 0, 0, 0, 0, 3, ALU, 4'b0000, 1, 1, CAP};
        tbl[1]  = '{1, 1, 0, 0, 1, 5, 1, 6, 1, 2, 5, 6, 7, ALU, 4'b0000, 1, 1, CAP};
        tbl[2]  = '{1, 1, 0, 0, 1, 9, 1, 9, 9, 0, 5, 9, 8, ALU, 4'b0000, 1, 1, CAP};
        tbl[3]  = '{1, 1, 0, 0, 1, 0, 1, 10, 0, 9, 10, 1, 0, ALU, 4'b0000, 1, 1, CAP};
        // load to r12, then its use stalls through the history
        tbl[4]  = '{1, 1, 0, 0, 0, 0, 0, 0, 1, 2, 5, 6, 12, LD, 4'b0000, 1, 1, CAP};
        tbl[5]  = '{1, 1, 0, 0, 0, 0, 0, 0, 12, 0, 0, 0, 0, ALU, 4'b0000, 0, 1, BUB};
        tbl[6]  = '{1, 1, 0, 0, 0, 0, 0, 0, 0, 12, 0, 0, 0, ALU, 4'b0000, 0, 1, BUB};
        tbl[7]  = '{1, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 12, 0, ALU, 4'b0000, 0, 1, BUB};
        tbl[8]  = '{1, 1, 0, 0, 0, 0, 0, 0, 0, 0, 12, 0, 13, ALU, 4'b0000, 1, 1, CAP};
        // store and load to r0 never stall
        tbl[9]  = '{1, 1, 0, 0, 0, 0, 0, 0, 1, 2, 5, 6, 14, ST, 4'b0000, 1, 1, CAP};
        tbl[10] = '{1, 1, 0, 0, 0, 0, 0, 0, 14, 0, 14, 0, 0, LD, 4'b0000, 1, 1, CAP};
        tbl[11] = '{1, 1, 0, 0, 1, 3, 0, 0, 0, 0, 0, 0, 17, ALU, 4'b0000, 1, 1, CAP};
        // back-pressure with forward patching
        tbl[12] = '{1, 1, 0, 0, 0, 0, 0, 0, 1, 2, 5, 6, 15, ALU, 4'b0000, 1, 1, CAP};
        tbl[13] = '{1, 0, 0, 0, 0, 0, 0, 0, 3, 0, 0, 0, 4, ALU, 4'b0000, 0, 1, HLD};
        tbl[14] = '{1, 0, 0, 0, 0, 0, 0, 0, 3, 0, 0, 0, 4, ALU, 4'b0101, 0, 1, HLD};
        tbl[15] = '{1, 1, 1, 0, 0, 0, 0, 0, 3, 0, 0, 0, 4, ALU, 4'b1010, 0, 0, HLD};
        tbl[16] = '{1, 1, 1, 0, 0, 0, 0, 0, 3, 0, 0, 0, 4, ALU, 4'b1111, 0, 0, HLD};
        // flush and empty advance
        tbl[17] = '{1, 0, 0, 1, 0, 0, 0, 0, 1, 2, 5, 6, 4, ALU, 4'b0000, 0, 1, BUB};
        tbl[18] = '{1, 1, 0, 0, 0, 0, 0, 0, 9, 10, 1, 2, 16, ALU, 4'b0000, 1, 1, CAP};
        tbl[19] = '{0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, ALU, 4'b0000, 1, 1, BUB};
        tbl[20] = '{1, 1, 0, 1, 0, 0, 0, 0, 1, 2, 5, 6, 18, ALU, 4'b0000, 1, 1, BUB};
        // load held under back-pressure, then stalls as it drains
        tbl[21] = '{1, 1, 0, 0, 0, 0, 0, 0, 1, 2, 5, 6, 20, LD, 4'b0000, 1, 1, CAP};
        tbl[22] = '{1, 0, 0, 0, 0, 0, 0, 0, 20, 0, 0, 0, 0, ALU, 4'b0001, 0, 1, HLD};
        tbl[23] = '{1, 1, 0, 0, 0, 0, 0, 0, 20, 0, 0, 0, 0, ALU, 4'b0000, 0, 1, BUB};
        tbl[24] = '{1, 1, 0, 0, 0, 0, 0, 0, 0, 0, 20, 0, 0, ALU, 4'b0000, 0, 1, BUB};
        tbl[25] = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, ALU, 4'b0000, 0, 1, HLD};
    end

    initial begin
        aresetn = 1'b0;
        {flush, reg_readygo, forward_stall} = '0;
        ex_allowin = 1'b1;
        {id_pc0, id_pc1, id_inst0, id_inst1, id_imm0, id_imm1} = '0;
        {id_uop0, id_uop1} = '0;
        {id_rj0, id_rj1, id_rk0, id_rk1, id_rd0, id_rd1} = '0;
        {wb_we0, wb_we1, wb_rd0, wb_rd1, wb_data0, wb_data1} = '0;
        {fwd_flag_j0, fwd_flag_j1, fwd_flag_k0, fwd_flag_k1} = '0;
        {fwd_data_j0, fwd_data_j1, fwd_data_k0, fwd_data_k1} = '0;
        foreach (shadow[i])
            shadow[i] = '0;
        foreach (m_hist[d])
            m_hist[d] = '0;
        model_bubble();
        repeat (4) @(posedge clk);
        @(negedge clk);
        // reset state while aresetn is still low
        check_entry();
        check_val("reg_allowin", 32'(reg_allowin), 32'(ex_allowin));
        @(posedge clk);
        aresetn <= 1'b1;
        for (int n = 0; n < NUM_ROWS; n++) begin
            run_row(n);
        end
        $display("%0d errors over %0d table rows", errors, NUM_ROWS);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* reg_read_stage.f */
rr_isa_pkg.sv
rr_pipe_pkg.sv
dual_regfile.sv
load_use_scoreboard.sv
ex_issue_reg.sv
reg_read_stage.sv
tb_reg_read_stage.sv

/* Bender.yml */
package:
  name: reg_read_stage

sources:
  - rr_isa_pkg.sv
  - rr_pipe_pkg.sv
  - dual_regfile.sv
  - load_use_scoreboard.sv
  - ex_issue_reg.sv
  - reg_read_stage.sv
  - target: test
    files:
      - tb_reg_read_stage.sv
